/* pc_prof_pkg.sv */
package pc_prof_pkg;

  // program counter and histogram geometry
  localparam int PC_WIDTH    = 32;
  localparam int ROW_BITS    = 4;
  localparam int ROW_LSB     = 2;
  localparam int ROWS        = 1 << ROW_BITS;
  localparam int CAT_BITS    = 3;
  localparam int NUM_CATS    = 1 << CAT_BITS;
  localparam int COUNT_WIDTH = 16;

  // one cause per cycle, code order is fixed
  typedef enum logic [CAT_BITS-1:0] {
    e_instr           = 3'd0,
    e_fp_instr        = 3'd1,
    e_icache_miss     = 3'd2,
    e_stall_remote_wb = 3'd3,
    e_branch_miss     = 3'd4,
    e_jalr_miss       = 3'd5,
    e_stall_depend    = 3'd6,
    e_unknown         = 3'd7
  } pc_cat_e;

  // what put the bubble into EXE
  typedef enum logic [1:0] {
    e_bubble_none   = 2'd0,
    e_bubble_branch = 2'd1,
    e_bubble_jalr   = 2'd2,
    e_bubble_depend = 2'd3
  } exe_bubble_e;

endpackage

/* exe_bubble_classifier.sv */
`timescale 1ns/1ns

module exe_bubble_classifier (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                stall_all_i,
  input  logic                                stall_id_i,
  input  logic                                stall_depend_i,
  input  logic                                branch_mispredict_i,
  input  logic                                jalr_mispredict_i,
  input  logic [pc_prof_pkg::PC_WIDTH-1:0]    id_pc_i,
  input  logic [pc_prof_pkg::PC_WIDTH-1:0]    exe_pc_i,
  output pc_prof_pkg::exe_bubble_e            bubble_type_o,
  output logic [pc_prof_pkg::PC_WIDTH-1:0]    bubble_pc_o
);

  pc_prof_pkg::exe_bubble_e            bubble_type_n;
  logic [pc_prof_pkg::PC_WIDTH-1:0]    bubble_pc_n;
  pc_prof_pkg::exe_bubble_e            bubble_type_r;
  logic [pc_prof_pkg::PC_WIDTH-1:0]    bubble_pc_r;

  // classify the slot that will enter EXE next cycle
  always_comb begin
    bubble_type_n = pc_prof_pkg::e_bubble_none;
    bubble_pc_n   = exe_pc_i;
    if (branch_mispredict_i) begin
      // the wrong-path slot belongs to the branch itself
      bubble_type_n = pc_prof_pkg::e_bubble_branch;
      bubble_pc_n   = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      bubble_type_n = pc_prof_pkg::e_bubble_jalr;
      bubble_pc_n   = exe_pc_i;
    end else if (stall_id_i && stall_depend_i) begin
      // blame the waiting instruction, not the producer
      bubble_type_n = pc_prof_pkg::e_bubble_depend;
      bubble_pc_n   = id_pc_i;
    end
  end

  // a stalled bubble keeps its owner
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bubble_type_r <= pc_prof_pkg::e_bubble_none;
      bubble_pc_r   <= '0;
    end else if (!stall_all_i) begin
      bubble_type_r <= bubble_type_n;
      bubble_pc_r   <= bubble_pc_n;
    end
  end

  assign bubble_type_o = bubble_type_r;
  assign bubble_pc_o   = bubble_pc_r;

endmodule

/* cycle_attributor.sv */
`timescale 1ns/1ns

module cycle_attributor (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                exe_valid_i,
  input  logic                                exe_icache_miss_i,
  input  logic                                fp_exe_valid_i,
  input  logic                                stall_all_i,
  input  logic                                stall_id_i,
  input  logic                                stall_remote_wb_i,
  input  logic [pc_prof_pkg::PC_WIDTH-1:0]    id_pc_i,
  input  logic [pc_prof_pkg::PC_WIDTH-1:0]    exe_pc_i,
  input  pc_prof_pkg::exe_bubble_e            bubble_type_i,
  input  logic [pc_prof_pkg::PC_WIDTH-1:0]    bubble_pc_i,
  output pc_prof_pkg::pc_cat_e                evt_cat_o,
  output logic [pc_prof_pkg::PC_WIDTH-1:0]    evt_pc_o
);

  logic [pc_prof_pkg::PC_WIDTH-1:0] fp_exe_pc_r;
  logic [pc_prof_pkg::PC_WIDTH-1:0] mem_pc_r;
  logic                             instr_hit;
  logic                             fp_instr_hit;
  logic                             remote_wb_hit;

  // FP-EXE pc follows ID whenever the front end advances
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fp_exe_pc_r <= '0;
    end else if (!stall_all_i && !stall_id_i) begin
      fp_exe_pc_r <= id_pc_i;
    end
  end

  // MEM pc only takes real instructions out of EXE
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_pc_r <= '0;
    end else if (!stall_all_i && (bubble_type_i == pc_prof_pkg::e_bubble_none)) begin
      mem_pc_r <= exe_pc_i;
    end
  end

  assign instr_hit     = exe_valid_i && !exe_icache_miss_i && !stall_all_i;
  assign fp_instr_hit  = fp_exe_valid_i && !stall_all_i;
  assign remote_wb_hit = stall_all_i && stall_remote_wb_i;

  // first matching rule wins
  always_comb begin
    evt_cat_o = pc_prof_pkg::e_unknown;
    evt_pc_o  = exe_pc_i;
    if (instr_hit) begin
      evt_cat_o = pc_prof_pkg::e_instr;
      evt_pc_o  = exe_pc_i;
    end else if (fp_instr_hit) begin
      evt_cat_o = pc_prof_pkg::e_fp_instr;
      evt_pc_o  = fp_exe_pc_r;
    end else if (exe_icache_miss_i) begin
      evt_cat_o = pc_prof_pkg::e_icache_miss;
      evt_pc_o  = exe_pc_i;
    end else if (remote_wb_hit) begin
      // the load sitting in MEM is the one waiting on the network
      evt_cat_o = pc_prof_pkg::e_stall_remote_wb;
      evt_pc_o  = mem_pc_r;
    end else begin
      case (bubble_type_i)
        pc_prof_pkg::e_bubble_branch: begin
          evt_cat_o = pc_prof_pkg::e_branch_miss;
          evt_pc_o  = bubble_pc_i;
        end
        pc_prof_pkg::e_bubble_jalr: begin
          evt_cat_o = pc_prof_pkg::e_jalr_miss;
          evt_pc_o  = bubble_pc_i;
        end
        pc_prof_pkg::e_bubble_depend: begin
          evt_cat_o = pc_prof_pkg::e_stall_depend;
          evt_pc_o  = bubble_pc_i;
        end
        default: begin
          evt_cat_o = pc_prof_pkg::e_unknown;
          evt_pc_o  = exe_pc_i;
        end
      endcase
    end
  end

endmodule

/* pc_histogram_table.sv */
`timescale 1ns/1ns

module pc_histogram_table (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  pc_prof_pkg::pc_cat_e                  evt_cat_i,
  input  logic [pc_prof_pkg::PC_WIDTH-1:0]      evt_pc_i,
  input  logic                                  rd_en_i,
  input  logic [pc_prof_pkg::ROW_BITS-1:0]      rd_row_i,
  input  pc_prof_pkg::pc_cat_e                  rd_cat_i,
  output logic [pc_prof_pkg::COUNT_WIDTH-1:0]   rd_data_o,
  output logic                                  rd_valid_o
);

  // one counter per slot and cause, addressed as {slot, cause}
  logic [pc_prof_pkg::COUNT_WIDTH-1:0] count_r [pc_prof_pkg::ROWS*pc_prof_pkg::NUM_CATS];

  logic [pc_prof_pkg::ROW_BITS-1:0]                      evt_row;
  logic [pc_prof_pkg::ROW_BITS+pc_prof_pkg::CAT_BITS-1:0] wr_idx;
  logic [pc_prof_pkg::ROW_BITS+pc_prof_pkg::CAT_BITS-1:0] rd_idx;
  logic [pc_prof_pkg::COUNT_WIDTH-1:0]                   wr_cur;
  logic                                                  wr_sat;
  logic                                                  rd_valid_r;
  logic [pc_prof_pkg::COUNT_WIDTH-1:0]                   rd_data_r;

  // word-aligned pcs, so the slot skips the low two bits
  assign evt_row = evt_pc_i[pc_prof_pkg::ROW_LSB +: pc_prof_pkg::ROW_BITS];
  assign wr_idx  = {evt_row, evt_cat_i};
  assign rd_idx  = {rd_row_i, rd_cat_i};

  assign wr_cur = count_r[wr_idx];
  assign wr_sat = &wr_cur;

  // one increment per cycle, held at all ones once full
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < pc_prof_pkg::ROWS * pc_prof_pkg::NUM_CATS; i++) begin
        count_r[i] <= '0;
      end
    end else if (!wr_sat) begin
      count_r[wr_idx] <= wr_cur + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_r <= 1'b0;
    end else begin
      rd_valid_r <= rd_en_i;
    end
  end

  // sampled before the same-edge increment lands
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_r <= count_r[rd_idx];
    end
  end

  assign rd_valid_o = rd_valid_r;
  assign rd_data_o  = rd_data_r;

endmodule

/* pc_profiler_top.sv */
`timescale 1ns/1ns

module pc_profiler_top (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  exe_valid_i,
  input  logic                                  exe_icache_miss_i,
  input  logic                                  fp_exe_valid_i,
  input  logic                                  stall_all_i,
  input  logic                                  stall_id_i,
  input  logic                                  stall_depend_i,
  input  logic                                  stall_remote_wb_i,
  input  logic                                  branch_mispredict_i,
  input  logic                                  jalr_mispredict_i,
  input  logic [pc_prof_pkg::PC_WIDTH-1:0]      id_pc_i,
  input  logic [pc_prof_pkg::PC_WIDTH-1:0]      exe_pc_i,
  input  logic                                  rd_en_i,
  input  logic [pc_prof_pkg::ROW_BITS-1:0]      rd_row_i,
  input  pc_prof_pkg::pc_cat_e                  rd_cat_i,
  output logic [pc_prof_pkg::COUNT_WIDTH-1:0]   rd_data_o,
  output logic                                  rd_valid_o,
  output pc_prof_pkg::pc_cat_e                  evt_cat_o,
  output logic [pc_prof_pkg::PC_WIDTH-1:0]      evt_pc_o
);

  pc_prof_pkg::exe_bubble_e          bubble_type;
  logic [pc_prof_pkg::PC_WIDTH-1:0]  bubble_pc;
  pc_prof_pkg::pc_cat_e              evt_cat;
  logic [pc_prof_pkg::PC_WIDTH-1:0]  evt_pc;

  exe_bubble_classifier i_exe_bubble_classifier (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .stall_all_i         (stall_all_i),
    .stall_id_i          (stall_id_i),
    .stall_depend_i      (stall_depend_i),
    .branch_mispredict_i (branch_mispredict_i),
    .jalr_mispredict_i   (jalr_mispredict_i),
    .id_pc_i             (id_pc_i),
    .exe_pc_i            (exe_pc_i),
    .bubble_type_o       (bubble_type),
    .bubble_pc_o         (bubble_pc)
  );

  cycle_attributor i_cycle_attributor (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .exe_valid_i       (exe_valid_i),
    .exe_icache_miss_i (exe_icache_miss_i),
    .fp_exe_valid_i    (fp_exe_valid_i),
    .stall_all_i       (stall_all_i),
    .stall_id_i        (stall_id_i),
    .stall_remote_wb_i (stall_remote_wb_i),
    .id_pc_i           (id_pc_i),
    .exe_pc_i          (exe_pc_i),
    .bubble_type_i     (bubble_type),
    .bubble_pc_i       (bubble_pc),
    .evt_cat_o         (evt_cat),
    .evt_pc_o          (evt_pc)
  );

  pc_histogram_table i_pc_histogram_table (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .evt_cat_i  (evt_cat),
    .evt_pc_i   (evt_pc),
    .rd_en_i    (rd_en_i),
    .rd_row_i   (rd_row_i),
    .rd_cat_i   (rd_cat_i),
    .rd_data_o  (rd_data_o),
    .rd_valid_o (rd_valid_o)
  );

  // per-cycle trace of what the table is counting
  assign evt_cat_o = evt_cat;
  assign evt_pc_o  = evt_pc;

endmodule

/* pc_profiler_checker.sv */
`timescale 1ns/1ns

module pc_profiler_checker (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  rd_en_i,
  input  logic                  rd_valid_i,
  input  pc_prof_pkg::pc_cat_e  evt_cat_i
);

  // a strobe always answers on the next edge
  rd_valid_after_strobe: assert property (
    @(posedge clk_i) disable iff (reset_i) rd_en_i |=> rd_valid_i
  ) else $error("rd_valid_o missing one cycle after rd_en_i");

  rd_valid_only_after_strobe: assert property (
    @(posedge clk_i) disable iff (reset_i) !rd_en_i |=> !rd_valid_i
  ) else $error("rd_valid_o high without a strobe one cycle before");

  rd_valid_low_in_reset: assert property (
    @(posedge clk_i) reset_i |=> !rd_valid_i
  ) else $error("rd_valid_o high while in reset");

  // every cycle gets a defined cause
  evt_cat_known: assert property (
    @(posedge clk_i) disable iff (reset_i) !$isunknown(evt_cat_i)
  ) else $error("evt_cat_o has unknown bits");

endmodule

bind pc_profiler_top pc_profiler_checker i_pc_profiler_checker (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .rd_en_i    (rd_en_i),
  .rd_valid_i (rd_valid_o),
  .evt_cat_i  (evt_cat_o)
);

/* pc_profiler_tb.sv */
`timescale 1ns/1ns

module pc_profiler_tb;

  localparam int    HALF_PERIOD  = 4;
  localparam int    RESET_CYCLES = 16;
  localparam int    DRIVE_DELAY  = 1;
  localparam int    CHECK_DELAY  = 2;
  localparam int    READ_TIMEOUT = 8;
  localparam int    MAX_LINES    = 500;
  localparam string VEC_FILE     = "pc_profiler_vectors.txt";

  // ascii codes that open a line of the vectors file
  localparam int CODE_CYCLE   = 67;
  localparam int CODE_READ    = 82;
  localparam int CODE_END     = 69;
  localparam int CODE_COMMENT = 35;

  // parked pc while reads are running, lands in slot 15
  localparam logic [pc_prof_pkg::PC_WIDTH-1:0] IDLE_PC = 32'h0000_003c;

  logic                                 clk_i = 1'b0;
  logic                                 reset_i;
  logic                                 exe_valid_i;
  logic                                 exe_icache_miss_i;
  logic                                 fp_exe_valid_i;
  logic                                 stall_all_i;
  logic                                 stall_id_i;
  logic                                 stall_depend_i;
  logic                                 stall_remote_wb_i;
  logic                                 branch_mispredict_i;
  logic                                 jalr_mispredict_i;
  logic [pc_prof_pkg::PC_WIDTH-1:0]     id_pc_i;
  logic [pc_prof_pkg::PC_WIDTH-1:0]     exe_pc_i;
  logic                                 rd_en_i;
  logic [pc_prof_pkg::ROW_BITS-1:0]     rd_row_i;
  pc_prof_pkg::pc_cat_e                 rd_cat_i;
  logic [pc_prof_pkg::COUNT_WIDTH-1:0]  rd_data_o;
  logic                                 rd_valid_o;
  pc_prof_pkg::pc_cat_e                 evt_cat_o;
  logic [pc_prof_pkg::PC_WIDTH-1:0]     evt_pc_o;

  pc_profiler_top i_pc_profiler_top (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .exe_valid_i         (exe_valid_i),
    .exe_icache_miss_i   (exe_icache_miss_i),
    .fp_exe_valid_i      (fp_exe_valid_i),
    .stall_all_i         (stall_all_i),
    .stall_id_i          (stall_id_i),
    .stall_depend_i      (stall_depend_i),
    .stall_remote_wb_i   (stall_remote_wb_i),
    .branch_mispredict_i (branch_mispredict_i),
    .jalr_mispredict_i   (jalr_mispredict_i),
    .id_pc_i             (id_pc_i),
    .exe_pc_i            (exe_pc_i),
    .rd_en_i             (rd_en_i),
    .rd_row_i            (rd_row_i),
    .rd_cat_i            (rd_cat_i),
    .rd_data_o           (rd_data_o),
    .rd_valid_o          (rd_valid_o),
    .evt_cat_o           (evt_cat_o),
    .evt_pc_o            (evt_pc_o)
  );

  always #HALF_PERIOD clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_cat(input string name, input pc_prof_pkg::pc_cat_e exp_val,
                           input pc_prof_pkg::pc_cat_e act_val);
    if (act_val !== exp_val) begin
      fail_run($sformatf("ERR t=%0t %s expected=%s(%0d) actual=%s(%0d)", $time, name,
                         exp_val.name(), exp_val, act_val.name(), act_val));
    end
  endtask

  task automatic check_pc(input string name, input logic [pc_prof_pkg::PC_WIDTH-1:0] exp_val,
                          input logic [pc_prof_pkg::PC_WIDTH-1:0] act_val);
    if (act_val !== exp_val) begin
      fail_run($sformatf("ERR t=%0t %s expected=%h actual=%h", $time, name, exp_val, act_val));
    end
  endtask

  task automatic check_count(input string name,
                             input logic [pc_prof_pkg::COUNT_WIDTH-1:0] exp_val,
                             input logic [pc_prof_pkg::COUNT_WIDTH-1:0] act_val);
    if (act_val !== exp_val) begin
      fail_run($sformatf("ERR t=%0t %s expected=%0d actual=%0d", $time, name, exp_val, act_val));
    end
  endtask

  // flag order matches the vectors file columns
  task automatic drive_flags(input logic [8:0] flags);
    {exe_valid_i, exe_icache_miss_i, fp_exe_valid_i, stall_all_i, stall_id_i,
     stall_depend_i, stall_remote_wb_i, branch_mispredict_i, jalr_mispredict_i} = flags;
  endtask

  task automatic run_cycles(input int rep, input logic [8:0] flags,
                            input logic [pc_prof_pkg::PC_WIDTH-1:0] id_pc,
                            input logic [pc_prof_pkg::PC_WIDTH-1:0] exe_pc,
                            input pc_prof_pkg::pc_cat_e exp_cat,
                            input logic [pc_prof_pkg::PC_WIDTH-1:0] exp_pc);
    for (int i = 0; i < rep; i++) begin
      drive_flags(flags);
      id_pc_i  = id_pc;
      exe_pc_i = exe_pc;
      #CHECK_DELAY;
      check_cat("evt_cat_o", exp_cat, evt_cat_o);
      check_pc("evt_pc_o", exp_pc, evt_pc_o);
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
  endtask

  // idle pipeline while the strobe is out
  task automatic read_counter(input logic [pc_prof_pkg::ROW_BITS-1:0] row,
                              input pc_prof_pkg::pc_cat_e cat,
                              input logic [pc_prof_pkg::COUNT_WIDTH-1:0] exp_count);
    int waited;
    waited = 0;
    drive_flags(9'b0);
    id_pc_i  = IDLE_PC;
    exe_pc_i = IDLE_PC;
    rd_en_i  = 1'b1;
    rd_row_i = row;
    rd_cat_i = cat;
    @(posedge clk_i);
    #DRIVE_DELAY;
    rd_en_i = 1'b0;
    while (!rd_valid_o && waited < READ_TIMEOUT) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      waited++;
    end
    if (!rd_valid_o) begin
      fail_run($sformatf("read of slot %0d cause %0d: the read result never arrived", row, cat));
    end
    if (waited != 0) begin
      fail_run($sformatf("read of slot %0d cause %0d arrived %0d cycles late", row, cat, waited));
    end
    check_count("rd_data_o", exp_count, rd_data_o);
  endtask

  function automatic int next_code(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch == 32 || ch == 9 || ch == 10 || ch == 13) begin
      ch = $fgetc(fd);
    end
    return ch;
  endfunction

  function automatic void skip_line(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endfunction

  initial begin : replay
    int                               fd;
    int                               code;
    int                               lines;
    int                               nread;
    int                               rep;
    int                               cat_val;
    int                               row_val;
    int                               cnt_val;
    logic [8:0]                       flags;
    logic [pc_prof_pkg::PC_WIDTH-1:0] id_val;
    logic [pc_prof_pkg::PC_WIDTH-1:0] exe_val;
    logic [pc_prof_pkg::PC_WIDTH-1:0] pc_val;
    bit                               done;

    reset_i = 1'b1;
    drive_flags(9'b0);
    id_pc_i  = IDLE_PC;
    exe_pc_i = IDLE_PC;
    rd_en_i  = 1'b0;
    rd_row_i = '0;
    rd_cat_i = pc_prof_pkg::e_instr;
    done     = 1'b0;
    lines    = 0;

    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      fail_run("cannot open the vectors file");
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    reset_i = 1'b0;

    while (!done) begin
      code = next_code(fd);
      lines++;
      if (lines > MAX_LINES) begin
        fail_run("vectors file runs past the line limit without an end line");
      end
      if (code == CODE_COMMENT) begin
        skip_line(fd);
      end else if (code == CODE_CYCLE) begin
        nread = $fscanf(fd, "%d %b %h %h %d %h", rep, flags, id_val, exe_val, cat_val, pc_val);
        if (nread != 6) begin
          fail_run("malformed cycle line in the vectors file");
        end
        run_cycles(rep, flags, id_val, exe_val,
                   pc_prof_pkg::pc_cat_e'(cat_val[pc_prof_pkg::CAT_BITS-1:0]), pc_val);
      end else if (code == CODE_READ) begin
        nread = $fscanf(fd, "%d %d %d", row_val, cat_val, cnt_val);
        if (nread != 3) begin
          fail_run("malformed read line in the vectors file");
        end
        read_counter(row_val[pc_prof_pkg::ROW_BITS-1:0],
                     pc_prof_pkg::pc_cat_e'(cat_val[pc_prof_pkg::CAT_BITS-1:0]),
                     cnt_val[pc_prof_pkg::COUNT_WIDTH-1:0]);
      end else if (code == CODE_END) begin
        done = 1'b1;
      end else if (code < 0) begin
        fail_run("vectors file ended without an end line");
      end else begin
        fail_run("unknown line code in the vectors file");
      end
    end
    $fclose(fd);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* pc_profiler_vectors.txt */
# C repeat flags(exe_valid icache fp_valid stall_all stall_id depend remote_wb br jalr)
#   id_pc exe_pc exp_cause exp_pc     R slot cause exp_count     E ends the run
# counters right after reset
R 15 7 0
R 15 7 1
R 1 0 0
R 3 6 0
R 8 0 0
# mispredict and dependency bubbles
C 1 100000000 00000108 00000104 0 00000104
C 1 100000010 0000010c 00000108 0 00000108
C 1 000000000 00000110 0000010c 4 00000108
C 1 100000001 00000114 00000110 0 00000110
C 3 000100000 00000118 00000114 5 00000110
C 1 000000000 00000118 00000114 5 00000110
C 1 100011000 00000118 00000114 0 00000114
C 1 000000000 00000118 00000118 6 00000118
# priority and tracker pcs
C 1 101000000 00000104 0000010c 0 0000010c
C 1 111000000 00000108 00000110 1 00000104
C 1 011100100 0000010c 00000114 2 00000114
C 2 001100100 0000010c 00000114 3 00000110
C 1 001010000 00000114 00000118 1 00000108
C 1 001000000 00000104 00000118 1 00000108
C 1 001000000 0000010c 00000118 1 00000104
C 1 100000011 00000104 00000114 0 00000114
C 1 000100100 00000104 0000010c 3 00000114
C 1 000100000 00000104 0000010c 4 00000114
C 1 000000000 00000104 0000010c 4 00000114
C 1 000000000 00000104 0000010c 7 0000010c
C 1 100011010 00000108 00000110 0 00000110
C 1 000000000 00000108 00000104 4 00000110
# 0x204 aliases into slot 1
C 3 100000000 00000108 00000204 0 00000204
# drive one counter past full scale
C 65540 100000000 00000120 00000120 0 00000120
# readout
R 1 0 4
R 2 0 1
R 2 4 1
R 4 0 2
R 4 5 4
R 5 0 2
R 6 6 1
R 3 0 1
R 1 1 2
R 5 2 1
R 4 3 2
R 2 1 2
R 5 3 1
R 5 4 2
R 3 7 1
R 4 4 1
R 8 0 65535
R 6 0 0
E

/* filelist.f */
pc_prof_pkg.sv
exe_bubble_classifier.sv
cycle_attributor.sv
pc_histogram_table.sv
pc_profiler_top.sv
pc_profiler_checker.sv
pc_profiler_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the profiler testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module pc_profiler_tb \
  -f filelist.f -o pc_profiler_sim \
  && ./obj_dir/pc_profiler_sim | tee /dev/stderr | grep -q "^STATUS: PASS$" \
  && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
